// File: compile.f
source/bcdPkg.sv
source/bcdAdder.sv
source/bcdSubtractor.sv
source/bcdResultStage.sv
source/bcdAlu.sv
tb/bcdAluChecker.sv
tb/bcdAluTb.sv

// File: tb/bcdAluTb.sv
`timescale 1ns/1ns

module bcdAluTb;

  localparam int numTests = 5;
  localparam int reqsPerTest = 200;
  localparam int slackCycles = 100;
  // one idle in four cycles on average with the division rounded up
  localparam int timeoutCycles = (numTests * reqsPerTest * 4 + 2) / 3 + slackCycles;

  logic           clk;
  logic           rstN;
  bcdPkg::bcdReqS req;
  bcdPkg::bcdResS res;
  int             errorCount;
  int             checkCount;
  int             errorsBefore = 0;
  int             checksBefore = 0;
  int             cycleCount = 0;
  logic [31:0]    rngState = 32'd54509;

  bcdAlu uut (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .res  (res)
  );

  bcdAluChecker resultCheck (
    .clk        (clk),
    .rstN       (rstN),
    .req        (req),
    .res        (res),
    .errorCount (errorCount),
    .checkCount (checkCount)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", timeoutCycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ==============================
  // stimulus helpers
  // ==============================

  // xorshift32
  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [bcdPkg::dataWidth-1:0] randomBcd();
    logic [bcdPkg::dataWidth-1:0] v;
    for (int d = 0; d < bcdPkg::numDigits; d++) begin
      v[4*d +: 4] = 4'(nextRand() % 10);
    end
    return v;
  endfunction

  // one random digit forced into A..F
  function automatic logic [bcdPkg::dataWidth-1:0] corruptDigit(
      input logic [bcdPkg::dataWidth-1:0] v);
    int d;
    d = nextRand() % bcdPkg::numDigits;
    v[4*d +: 4] = 4'(10 + nextRand() % 6);
    return v;
  endfunction

  function automatic bcdPkg::bcdOpE randomOp();
    return (nextRand() % 2 == 0) ? bcdPkg::opAdd : bcdPkg::opSub;
  endfunction

  task automatic sendRequest(input bcdPkg::bcdOpE op, input logic [bcdPkg::dataWidth-1:0] a,
                             input logic [bcdPkg::dataWidth-1:0] b, input logic cin);
    bcdPkg::bcdReqS next;
    next.valid = 1'b1;
    next.op = op;
    next.a = a;
    next.b = b;
    next.carryIn = cin;
    @(posedge clk);
    req <= next;
  endtask

  // valid low while the operands move on to new random values
  // so the held result data cannot match by accident
  task automatic idleCycle();
    bcdPkg::bcdReqS idle;
    idle.valid = 1'b0;
    idle.op = randomOp();
    idle.a = randomBcd();
    idle.b = randomBcd();
    idle.carryIn = 1'(nextRand() % 2);
    @(posedge clk);
    req <= idle;
  endtask

  // about a third of the requests get an idle cycle in front
  task automatic maybeIdle();
    if (nextRand() % 3 == 0) idleCycle();
  endtask

  // ==============================
  // test sequence
  // ==============================

  task automatic runTest(input int kind);
    logic [31:0]                  pick;
    logic [bcdPkg::dataWidth-1:0] a;
    logic [bcdPkg::dataWidth-1:0] b;
    for (int n = 0; n < reqsPerTest; n++) begin
      maybeIdle();
      a = randomBcd();
      b = randomBcd();
      case (kind)
        1: sendRequest(bcdPkg::opAdd, a, b, 1'(nextRand() % 2));
        2: sendRequest(bcdPkg::opSub, a, b, 1'(nextRand() % 2));
        3: begin
          // full ripple corners plus zero results
          pick = nextRand() % 4;
          case (pick)
            0: sendRequest(bcdPkg::opAdd, {bcdPkg::numDigits{4'h9}}, '0, 1'b1);
            1: sendRequest(bcdPkg::opSub, '0, '0, 1'b1);
            2: sendRequest(bcdPkg::opAdd, '0, '0, 1'b0);
            default: sendRequest(bcdPkg::opSub, a, a, 1'b0);
          endcase
        end
        4: begin
          pick = nextRand() % 3;
          if (pick != 1) a = corruptDigit(a);
          if (pick != 0) b = corruptDigit(b);
          sendRequest(randomOp(), a, b, 1'(nextRand() % 2));
        end
        default: sendRequest(randomOp(), a, b, 1'(nextRand() % 2));
      endcase
    end
  endtask

  // drain the pipe and then report this test's share of the counts
  task automatic endTest(input int num, input string name);
    int newErrors;
    int newChecks;
    repeat (3) idleCycle();
    @(negedge clk);
    newErrors = errorCount - errorsBefore;
    newChecks = checkCount - checksBefore;
    $display("test %0d %s: %0d results checked, %0d errors", num, name, newChecks,
             newErrors);
    errorsBefore = errorCount;
    checksBefore = checkCount;
  endtask

  initial begin
    rstN = 1'b0;
    req = '0;
    // reset held for four cycles
    repeat (4) @(posedge clk);
    rstN <= 1'b1;

    runTest(1);
    endTest(1, "random add");
    runTest(2);
    endTest(2, "random subtract");
    runTest(3);
    endTest(3, "carry and borrow ripple");
    runTest(4);
    endTest(4, "non-decimal digits");
    runTest(5);
    endTest(5, "mixed back-to-back");

    $display("%0d tests, %0d results checked, %0d errors", numTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb/bcdAluChecker.sv
`timescale 1ns/1ns

// watches the DUT ports, predicts each result from the digit rules
// and compares it one cycle after the request
module bcdAluChecker (
  input  logic           clk,
  input  logic           rstN,
  input  bcdPkg::bcdReqS req,
  input  bcdPkg::bcdResS res,
  output int             errorCount,
  output int             checkCount
);

  int errors = 0;
  int checked = 0;
  // a request was seen last edge, its result is due now
  logic pending;
  bcdPkg::bcdResS expected;
  // last delivered result, the data fields must hold it while idle
  bcdPkg::bcdResS lastExp;

  assign errorCount = errors;
  assign checkCount = checked;

  // ==============================
  // reference model
  // ==============================

  // digit by digit in plain integers, link is the carry or borrow
  function automatic bcdPkg::bcdResS expectedResult(input bcdPkg::bcdReqS r);
    bcdPkg::bcdResS e;
    int ad;
    int bd;
    int raw;
    int dig;
    int link;
    logic bad;
    e = '0;
    link = r.carryIn;
    bad = 1'b0;
    for (int d = 0; d < bcdPkg::numDigits; d++) begin
      ad = r.a[4*d +: 4];
      bd = r.b[4*d +: 4];
      if (ad > 9 || bd > 9) bad = 1'b1;
      if (r.op == bcdPkg::opAdd) begin
        raw = ad + bd + link;
        if (raw <= 9) begin
          dig = raw;
          link = 0;
        end else if (raw <= 19) begin
          dig = raw - 10;
          link = 1;
        end else begin
          dig = 9;
          link = 1;
        end
      end else begin
        raw = ad - bd - link;
        if (raw >= 0 && raw <= 9) begin
          dig = raw;
          link = 0;
        end else if (raw >= -10 && raw <= -1) begin
          dig = raw + 10;
          link = 1;
        end else begin
          // out of range either way saturates
          dig = 9;
          link = 1;
        end
      end
      e.value[4*d +: 4] = 4'(dig);
    end
    e.valid = 1'b1;
    e.carryOut = link[0];
    e.zero = (e.value == '0);
    e.digitError = bad;
    return e;
  endfunction

  task automatic checkField(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expVal, actVal);
      errors++;
    end
  endtask

  task automatic compareData(input bcdPkg::bcdResS e);
    checkField("res.value", 32'(e.value), 32'(res.value));
    checkField("res.carryOut", 32'(e.carryOut), 32'(res.carryOut));
    checkField("res.zero", 32'(e.zero), 32'(res.zero));
    checkField("res.digitError", 32'(e.digitError), 32'(res.digitError));
  endtask

  // ==============================
  // per-edge compare
  // ==============================

  // res and req read here are the values from before this edge
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pending = 1'b0;
      expected = '0;
      lastExp = '0;
    end else begin
      if (pending) begin
        checked++;
        if (!res.valid) begin
          $display("result missing: no valid pulse one cycle after a request");
          errors++;
        end
        compareData(expected);
        lastExp = expected;
      end else begin
        if (res.valid) begin
          $display("unexpected valid pulse with no request one cycle earlier");
          errors++;
        end
        // idle cycle, data fields hold
        compareData(lastExp);
      end
      pending = req.valid;
      if (req.valid) begin
        expected = expectedResult(req);
      end
    end
  end

endmodule

// File: source/bcdAlu.sv
`timescale 1ns/1ns

// top level of the decimal arithmetic unit
// both units see every operand pair, the result stage chooses
module bcdAlu (
  input  logic           clk,
  input  logic           rstN,
  input  bcdPkg::bcdReqS req,
  output bcdPkg::bcdResS res
);

  // combinational unit outputs into the result stage
  bcdPkg::bcdArithS sumOut;
  bcdPkg::bcdArithS diffOut;

  // decimal adder
  bcdAdder adder (
    .a       (req.a),
    .b       (req.b),
    .carryIn (req.carryIn),
    .sumOut  (sumOut)
  );

  // decimal subtractor, carryIn acts as borrow in
  bcdSubtractor subtractor (
    .a       (req.a),
    .b       (req.b),
    .carryIn (req.carryIn),
    .diffOut (diffOut)
  );

  // select, flags and the single pipeline register
  bcdResultStage resultStage (
    .clk    (clk),
    .rstN   (rstN),
    .req    (req),
    .sumIn  (sumOut),
    .diffIn (diffOut),
    .res    (res)
  );

endmodule

// File: source/bcdResultStage.sv
`timescale 1ns/1ns

// picks the adder or subtractor result by opcode,
// derives the flags and registers everything for one cycle of latency
module bcdResultStage (
  input  logic             clk,
  input  logic             rstN,
  input  bcdPkg::bcdReqS   req,
  input  bcdPkg::bcdArithS sumIn,
  input  bcdPkg::bcdArithS diffIn,
  output bcdPkg::bcdResS   res
);

  // ==============================
  // result select
  // ==============================

  // unit chosen by the opcode of this cycle's request
  bcdPkg::bcdArithS picked;
  // all digits of the picked value are zero
  logic             pickedZero;

  always_comb begin
    case (req.op)
      bcdPkg::opSub: picked = diffIn;
      default:       picked = sumIn;
    endcase
  end

  assign pickedZero = (picked.value == '0);

  // ==============================
  // output register
  // ==============================

  // valid pulses for exactly one cycle per request
  // data fields only load on a request and otherwise hold
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      res <= '0;
    end else begin
      res.valid <= req.valid;
      if (req.valid) begin
        res.value      <= picked.value;
        res.carryOut   <= picked.carryOut;
        res.zero       <= pickedZero;
        res.digitError <= picked.badDigit;
      end
    end
  end

  // ==============================
  // checks
  // ==============================

  // a request always comes back on the next cycle, never stalled
  assert property (@(posedge clk) disable iff (!rstN)
    req.valid |=> res.valid)
    else $error("result valid missing one cycle after a request");

  // and no result appears without a request
  assert property (@(posedge clk) disable iff (!rstN)
    !req.valid |=> !res.valid)
    else $error("result valid without a request one cycle earlier");

  // the registered flag agrees with the registered value
  assert property (@(posedge clk) disable iff (!rstN)
    res.zero |-> (res.value == '0))
    else $error("zero flag set on a nonzero result");

endmodule

// File: source/bcdSubtractor.sv
`timescale 1ns/1ns

// rippled packed-BCD subtractor, a minus b minus borrow
// mirrors the adder, the borrow ripples up the same way
module bcdSubtractor (
  input  logic [bcdPkg::dataWidth-1:0] a,
  input  logic [bcdPkg::dataWidth-1:0] b,
  input  logic                         carryIn,
  output bcdPkg::bcdArithS             diffOut
);

  // borrowChain[i] enters digit i
  logic [bcdPkg::numDigits:0]   borrowChain;
  logic [bcdPkg::numDigits-1:0] digitBad;
  logic [bcdPkg::dataWidth-1:0] diffValue;

  // lowest digit borrows from the external carry input
  assign borrowChain[0] = carryIn;

  // ==============================
  // per-digit subtract and adjust
  // ==============================

  for (genvar i = 0; i < bcdPkg::numDigits; i++) begin : genDigit
    logic [3:0] aDigit;
    logic [3:0] bDigit;
    // two's complement in five bits, range -16..15
    logic [4:0] rawDiff;
    logic [3:0] adjDigit;
    logic       adjBorrow;

    assign aDigit  = a[4*i +: 4];
    assign bDigit  = b[4*i +: 4];
    assign rawDiff = {1'b0, aDigit} - {1'b0, bDigit} - {4'd0, borrowChain[i]};

    // subtract adjust
    // 0..9 pass, -10..-1 get ten added back with a borrow
    // anything else saturates to 9 with a borrow
    always_comb begin
      if (rawDiff <= 5'd9) begin
        adjDigit  = rawDiff[3:0];
        adjBorrow = 1'b0;
      end else if (rawDiff >= 5'h16) begin
        // -10 is 5'h16, so adding ten lands on 0..9
        adjDigit  = 4'(rawDiff + 5'd10);
        adjBorrow = 1'b1;
      end else begin
        adjDigit  = 4'd9;
        adjBorrow = 1'b1;
      end
    end

    assign diffValue[4*i +: 4] = adjDigit;
    assign borrowChain[i+1]    = adjBorrow;
    assign digitBad[i]         = (aDigit > 4'd9) || (bDigit > 4'd9);
  end

  assign diffOut.value    = diffValue;
  assign diffOut.carryOut = borrowChain[bcdPkg::numDigits];
  assign diffOut.badDigit = |digitBad;

  // clean operands must give a clean decimal result in every digit
  always_comb begin
    if (!diffOut.badDigit) begin
      for (int d = 0; d < bcdPkg::numDigits; d++) begin
        assert final (diffOut.value[4*d +: 4] <= 4'd9)
          else $error("subtractor digit %0d above 9 with legal operands", d);
      end
    end
  end

endmodule

// File: source/bcdAdder.sv
`timescale 1ns/1ns

// rippled packed-BCD adder
// purely combinational, one adjust stage per digit
module bcdAdder (
  input  logic [bcdPkg::dataWidth-1:0] a,
  input  logic [bcdPkg::dataWidth-1:0] b,
  input  logic                         carryIn,
  output bcdPkg::bcdArithS             sumOut
);

  // carryChain[i] enters digit i, the top entry leaves the unit
  logic [bcdPkg::numDigits:0]   carryChain;
  // per-digit out-of-range flags on either operand
  logic [bcdPkg::numDigits-1:0] digitBad;
  // adjusted digits, packed back in order
  logic [bcdPkg::dataWidth-1:0] sumValue;

  assign carryChain[0] = carryIn;

  // ==============================
  // per-digit add and adjust
  // ==============================

  for (genvar i = 0; i < bcdPkg::numDigits; i++) begin : genDigit
    logic [3:0] aDigit;
    logic [3:0] bDigit;
    // five bits cover 15 + 15 + 1
    logic [4:0] rawSum;
    logic [3:0] adjDigit;
    logic       adjCarry;

    assign aDigit = a[4*i +: 4];
    assign bDigit = b[4*i +: 4];
    assign rawSum = {1'b0, aDigit} + {1'b0, bDigit} + {4'd0, carryChain[i]};

    // add adjust
    // 0..9 pass, 10..19 wrap by ten with carry, above that saturate
    always_comb begin
      if (rawSum <= 5'd9) begin
        adjDigit = rawSum[3:0];
        adjCarry = 1'b0;
      end else if (rawSum <= 5'd19) begin
        // low four bits of the sum minus ten
        adjDigit = 4'(rawSum - 5'd10);
        adjCarry = 1'b1;
      end else begin
        adjDigit = 4'd9;
        adjCarry = 1'b1;
      end
    end

    assign sumValue[4*i +: 4] = adjDigit;
    assign carryChain[i+1]    = adjCarry;
    // hex digits A..F are not decimal
    assign digitBad[i]        = (aDigit > 4'd9) || (bDigit > 4'd9);
  end

  // ==============================
  // pack the unit output
  // ==============================

  assign sumOut.value    = sumValue;
  assign sumOut.carryOut = carryChain[bcdPkg::numDigits];
  assign sumOut.badDigit = |digitBad;

endmodule

// File: source/bcdPkg.sv
package bcdPkg;

  // ==============================
  // sizing
  // ==============================

  // number of packed BCD digits in one operand
  // 2 and 8 also work without other changes
  localparam int numDigits = 4;

  // four bits per digit
  localparam int dataWidth = 4 * numDigits;

  // ==============================
  // opcodes
  // ==============================

  // decimal add or decimal subtract
  typedef enum logic {
    opAdd = 1'b0,
    opSub = 1'b1
  } bcdOpE;

  // ==============================
  // bus structs
  // ==============================

  // one request from the core, a single-cycle strobe with operands
  typedef struct packed {
    logic                 valid;
    bcdOpE                op;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    // carry in for add, borrow in for sub
    logic                 carryIn;
  } bcdReqS;

  // output of one arithmetic unit, adder or subtractor
  typedef struct packed {
    logic [dataWidth-1:0] value;
    // carry out of the top digit for add, borrow for sub
    logic                 carryOut;
    // some input digit was above 9
    logic                 badDigit;
  } bcdArithS;

  // registered result back to the core
  typedef struct packed {
    logic                 valid;
    logic [dataWidth-1:0] value;
    logic                 carryOut;
    logic                 zero;
    logic                 digitError;
  } bcdResS;

endpackage
